//--- design/mem_pkg.sv
package mem_pkg;

    // Bus geometry
    localparam int DATA_W  = 32;
    localparam int SEL_W   = DATA_W / 8;
    localparam int ADR_LSB = $clog2(SEL_W);

    // Pattern loaded into every word after reset
    localparam logic [DATA_W-1:0] INIT_WORD = 32'hc3a5_5a3c;

    // One RAM word, seen whole or lane by lane
    typedef union packed {
        logic [DATA_W-1:0]     word;
        logic [SEL_W-1:0][7:0] bytes;
    } mem_word_u;

endpackage

//--- design/init_counter.sv
`timescale 1ns/1ps

module init_counter #(
    parameter int MEM_WORDS = 256,
    localparam int ADDR_W   = $clog2(MEM_WORDS)
) (
    input  logic              wb_clk_i,
    input  logic              arst_n_i,
    input  logic              step_i,
    output logic [ADDR_W-1:0] addr_o,
    output logic              done_o
);

    localparam logic [ADDR_W-1:0] LAST_IDX = ADDR_W'(MEM_WORDS - 1);

    logic [ADDR_W-1:0] addr_q;
    logic              done_q;

    // Wraps back to zero after the last word, done stays set
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_q <= '0;
            done_q <= 1'b0;
        end else if (step_i) begin
            addr_q <= addr_q + 1'b1;
            if (addr_q == LAST_IDX) begin
                done_q <= 1'b1;
            end
        end
    end

    assign addr_o = addr_q;
    assign done_o = done_q;

    // The FSM must stop stepping once the fill is complete
    a_no_step_after_done: assert property (
        @(posedge wb_clk_i) disable iff (!arst_n_i)
        done_q |-> !step_i
    ) else $error("init_counter stepped after done");

endmodule

//--- design/sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
    parameter int MEM_WORDS = 256,
    localparam int ADDR_W   = $clog2(MEM_WORDS)
) (
    input  logic                        wb_clk_i,
    input  logic                        en_i,
    input  logic                        we_i,
    input  logic                        init_mode_i,
    input  logic [ADDR_W-1:0]           host_addr_i,
    input  logic [ADDR_W-1:0]           init_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  wdata_i,
    input  logic [mem_pkg::SEL_W-1:0]   sel_i,
    output logic [mem_pkg::DATA_W-1:0]  rdata_o
);

    mem_pkg::mem_word_u mem [MEM_WORDS];

    logic [ADDR_W-1:0]          addr;
    mem_pkg::mem_word_u         wr_word;
    logic [mem_pkg::SEL_W-1:0]  wr_sel;
    logic [mem_pkg::DATA_W-1:0] rdata_q;

    // Init port takes over address, data and lanes
    always_comb begin
        if (init_mode_i) begin
            addr         = init_addr_i;
            wr_word.word = mem_pkg::INIT_WORD;
            wr_sel       = '1;
        end else begin
            addr         = host_addr_i;
            wr_word.word = wdata_i;
            wr_sel       = sel_i;
        end
    end

    // Lane-masked write through the byte view
    always_ff @(posedge wb_clk_i) begin
        if (en_i && we_i) begin
            for (int lane = 0; lane < mem_pkg::SEL_W; lane++) begin
                if (wr_sel[lane]) begin
                    mem[addr].bytes[lane] <= wr_word.bytes[lane];
                end
            end
        end
    end

    // Registered read, holds between reads
    always_ff @(posedge wb_clk_i) begin
        if (en_i && !we_i) begin
            rdata_q <= mem[addr].word;
        end
    end

    assign rdata_o = rdata_q;

endmodule

//--- design/mem_fsm.sv
`timescale 1ns/1ps

module mem_fsm #(
    parameter int MEM_WORDS = 256,
    localparam int WADR_W   = 32 - mem_pkg::ADR_LSB
) (
    input  logic              wb_clk_i,
    input  logic              arst_n_i,
    input  logic              cyc_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [WADR_W-1:0] word_adr_i,
    input  logic              init_done_i,
    output logic              init_step_o,
    output logic              init_mode_o,
    output logic              ram_en_o,
    output logic              ram_we_o,
    output logic              ack_o,
    output logic              err_o,
    output logic              busy_o
);

    localparam logic [2:0] S_INIT      = 3'd0;
    localparam logic [2:0] S_IDLE      = 3'd1;
    localparam logic [2:0] S_WRITE     = 3'd2;
    localparam logic [2:0] S_READ_WAIT = 3'd3;
    localparam logic [2:0] S_READ_ACK  = 3'd4;
    localparam logic [2:0] S_ERROR     = 3'd5;
    localparam logic [2:0] S_RECOVER   = 3'd6;

    localparam logic [WADR_W-1:0] WORD_LIMIT = WADR_W'(MEM_WORDS);

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic       req;
    logic       in_range;
    logic       init_fill;
    logic       ack_q;
    logic       err_q;

    assign req       = cyc_i && stb_i;
    assign in_range  = word_adr_i < WORD_LIMIT;
    assign init_fill = (state_q == S_INIT) && !init_done_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_INIT:      if (init_done_i) state_d = S_IDLE;
            S_IDLE: begin
                if (req) begin
                    if (!in_range) state_d = S_ERROR;
                    else if (we_i) state_d = S_WRITE;
                    else           state_d = S_READ_WAIT;
                end
            end
            S_WRITE:     state_d = S_RECOVER;
            S_READ_WAIT: state_d = S_READ_ACK;
            S_READ_ACK:  state_d = S_RECOVER;
            S_ERROR:     state_d = S_RECOVER;
            // Termination cycle where stb may still be high
            default:     state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_INIT;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_q   <= (state_q == S_WRITE) || (state_q == S_READ_ACK);
            err_q   <= (state_q == S_ERROR);
        end
    end

    assign init_step_o = init_fill;
    assign init_mode_o = (state_q == S_INIT);
    assign ram_en_o    = init_fill || (state_q == S_WRITE) || (state_q == S_READ_WAIT);
    assign ram_we_o    = init_fill || (state_q == S_WRITE);
    assign ack_o       = ack_q;
    assign err_o       = err_q;
    assign busy_o      = init_fill;

    a_ack_err_excl: assert property (
        @(posedge wb_clk_i) disable iff (!arst_n_i)
        !(ack_o && err_o)
    ) else $error("ack and err high together");

    // Master must still hold the request when it terminates
    a_term_in_cycle: assert property (
        @(posedge wb_clk_i) disable iff (!arst_n_i)
        (ack_o || err_o) |-> (cyc_i && stb_i)
    ) else $error("termination outside an active request");

    // Host writes only while an in-range write request is still on the bus
    a_ram_we_source: assert property (
        @(posedge wb_clk_i) disable iff (!arst_n_i)
        ram_we_o && !init_mode_o |-> req && we_i && in_range
    ) else $error("RAM write outside INIT or WRITE");

endmodule

//--- design/wb_mem_top.sv
`timescale 1ns/1ps

module wb_mem_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                        wb_clk_i,
    input  logic                        arst_n_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [31:0]                 wb_adr_i,
    input  logic [mem_pkg::DATA_W-1:0]  wb_dat_i,
    input  logic [mem_pkg::SEL_W-1:0]   wb_sel_i,
    output logic                        wb_ack_o,
    output logic                        wb_err_o,
    output logic [mem_pkg::DATA_W-1:0]  wb_dat_o,
    output logic                        init_busy_o
);

    localparam int ADDR_W = $clog2(MEM_WORDS);
    localparam int WADR_W = 32 - mem_pkg::ADR_LSB;

    logic [WADR_W-1:0] word_adr;
    logic [ADDR_W-1:0] host_addr;
    logic [ADDR_W-1:0] init_addr;
    logic              init_done;
    logic              init_step;
    logic              init_mode;
    logic              ram_en;
    logic              ram_we;

    // Byte address to word index
    assign word_adr  = wb_adr_i[31:mem_pkg::ADR_LSB];
    assign host_addr = wb_adr_i[mem_pkg::ADR_LSB +: ADDR_W];

    mem_fsm #(
        .MEM_WORDS (MEM_WORDS)
    ) u_fsm (
        .wb_clk_i    (wb_clk_i),
        .arst_n_i    (arst_n_i),
        .cyc_i       (wb_cyc_i),
        .stb_i       (wb_stb_i),
        .we_i        (wb_we_i),
        .word_adr_i  (word_adr),
        .init_done_i (init_done),
        .init_step_o (init_step),
        .init_mode_o (init_mode),
        .ram_en_o    (ram_en),
        .ram_we_o    (ram_we),
        .ack_o       (wb_ack_o),
        .err_o       (wb_err_o),
        .busy_o      (init_busy_o)
    );

    init_counter #(
        .MEM_WORDS (MEM_WORDS)
    ) u_init_cnt (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (arst_n_i),
        .step_i   (init_step),
        .addr_o   (init_addr),
        .done_o   (init_done)
    );

    sram_bank #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .wb_clk_i    (wb_clk_i),
        .en_i        (ram_en),
        .we_i        (ram_we),
        .init_mode_i (init_mode),
        .host_addr_i (host_addr),
        .init_addr_i (init_addr),
        .wdata_i     (wb_dat_i),
        .sel_i       (wb_sel_i),
        .rdata_o     (wb_dat_o)
    );

endmodule

//--- sim/tb_wb_tasks.svh
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Holds one request until ack or err shows up
task automatic present_request(input logic we, input logic [31:0] adr,
                               input logic [31:0] dat, input logic [3:0] sel,
                               input logic [31:0] expect_data);
    @(posedge wb_clk_i);
    wb_cyc_i  <= 1'b1;
    wb_stb_i  <= 1'b1;
    wb_we_i   <= we;
    wb_adr_i  <= adr;
    wb_dat_i  <= dat;
    wb_sel_i  <= sel;
    exp_rdata <= expect_data;
    req_id    <= req_id + 16'd1;
    do begin
        @(negedge wb_clk_i);
    end while (!(wb_ack_o || wb_err_o));
endtask

task automatic write_lanes(input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel);
    mem_pkg::mem_word_u wr;
    int                 idx;
    wr.word = dat;
    idx     = int'(adr >> mem_pkg::ADR_LSB);
    // Out of range writes leave the memory alone
    if ((adr >> mem_pkg::ADR_LSB) < MEM_WORDS) begin
        for (int lane = 0; lane < mem_pkg::SEL_W; lane++) begin
            if (sel[lane]) begin
                shadow[idx].bytes[lane] = wr.bytes[lane];
            end
        end
    end
    present_request(1'b1, adr, dat, sel, exp_rdata);
endtask

task automatic read_word(input logic [31:0] adr);
    logic [31:0] expect_data;
    expect_data = exp_rdata;
    if ((adr >> mem_pkg::ADR_LSB) < MEM_WORDS) begin
        expect_data = shadow[int'(adr >> mem_pkg::ADR_LSB)].word;
    end
    present_request(1'b0, adr, 32'h0, 4'hf, expect_data);
endtask

task automatic idle_bus(input int cycles);
    repeat (cycles) begin
        @(posedge wb_clk_i);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
    end
endtask

//--- sim/tb_wb_mem.sv
`timescale 1ns/1ps

module tb_wb_mem;

    localparam int MEM_WORDS  = 64;
    localparam int CLK_PERIOD = 100;
    localparam int N_RANDOM   = 200;
    // Init read-back, latency pair, lane pairs, range trio, random traffic
    localparam int N_ACCESSES = MEM_WORDS + 2 + 8 + 3 + N_RANDOM;
    localparam int WATCHDOG_CYCLES = MEM_WORDS + 4 * N_ACCESSES + 50;

    logic                       wb_clk_i;
    logic                       arst_n_i;
    logic                       wb_cyc_i;
    logic                       wb_stb_i;
    logic                       wb_we_i;
    logic [31:0]                wb_adr_i;
    logic [mem_pkg::DATA_W-1:0] wb_dat_i;
    logic [mem_pkg::SEL_W-1:0]  wb_sel_i;
    logic                       wb_ack_o;
    logic                       wb_err_o;
    logic [mem_pkg::DATA_W-1:0] wb_dat_o;
    logic                       init_busy_o;

    // Reference copy of the RAM merged lane by lane
    mem_pkg::mem_word_u         shadow [MEM_WORDS];
    logic [mem_pkg::DATA_W-1:0] exp_rdata;
    logic [15:0]                req_id;
    logic [15:0]                req_id_q;
    int                         busy_cycles;
    logic [31:0]                rng;
    string                      test_name;
    logic                       term;
    logic                       in_window;
    logic                       req_new;

    wb_mem_top #(
        .MEM_WORDS (MEM_WORDS)
    ) dut (
        .wb_clk_i    (wb_clk_i),
        .arst_n_i    (arst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_ack_o    (wb_ack_o),
        .wb_err_o    (wb_err_o),
        .wb_dat_o    (wb_dat_o),
        .init_busy_o (init_busy_o)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    `include "tb_wb_tasks.svh"

    assign term      = wb_ack_o || wb_err_o;
    assign in_window = (wb_adr_i >> mem_pkg::ADR_LSB) < MEM_WORDS;
    // High in the one cycle where the DUT first sees a request
    assign req_new   = wb_cyc_i && wb_stb_i && (req_id != req_id_q);

    always @(posedge wb_clk_i) begin
        req_id_q <= req_id;
        if (arst_n_i && init_busy_o) begin
            busy_cycles <= busy_cycles + 1;
        end
    end

    a_term_excl: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        !(wb_ack_o && wb_err_o)
    ) else report_failure($sformatf("In %s ack and err were high together", test_name));

    a_quiet_init: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        init_busy_o |-> !term
    ) else report_failure($sformatf("In %s a bus cycle ended during init", test_name));

    a_busy_len: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        $fell(init_busy_o) |-> busy_cycles == MEM_WORDS
    ) else report_failure($sformatf("** Error init busy cycles in %s: expected %0d, actual %0d",
        test_name, MEM_WORDS, busy_cycles));

    a_write_lat: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        req_new && wb_we_i && in_window && !init_busy_o |->
            !term ##1 !term ##1 (wb_ack_o && !wb_err_o)
    ) else report_failure($sformatf("In %s a write was not acked one cycle after sampling",
        test_name));

    a_read_lat: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        req_new && !wb_we_i && in_window && !init_busy_o |->
            !term ##1 !term ##1 !term ##1 (wb_ack_o && !wb_err_o)
    ) else report_failure($sformatf("In %s a read was not acked two cycles after sampling",
        test_name));

    a_err_lat: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        req_new && !in_window && !init_busy_o |->
            !term ##1 !term ##1 (wb_err_o && !wb_ack_o)
    ) else report_failure($sformatf("In %s an out of range access did not end in err",
        test_name));

    a_read_data: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        wb_ack_o && !wb_we_i |-> wb_dat_o == exp_rdata
    ) else report_failure($sformatf("** Error read data in %s: expected %h, actual %h",
        test_name, $sampled(exp_rdata), $sampled(wb_dat_o)));

    a_single_pulse: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        term |=> !term
    ) else report_failure($sformatf("In %s a termination lasted more than one cycle",
        test_name));

    // A request may only end or be replaced right after its termination
    a_req_ended: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        $past(wb_stb_i) && (!wb_stb_i || req_new) |-> $past(term)
    ) else report_failure($sformatf("In %s a request ended without a termination",
        test_name));

    initial begin
        wb_clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure($sformatf("Timeout, the run did not finish within %0d clock cycles",
            WATCHDOG_CYCLES));
    end

    initial begin
        logic [mem_pkg::SEL_W-1:0] lanes [4];
        logic [31:0]               adr;
        logic                      we;
        logic [mem_pkg::SEL_W-1:0] sel;
        arst_n_i    = 1'b0;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        wb_sel_i    = '0;
        exp_rdata   = '0;
        req_id      = '0;
        busy_cycles = 0;
        rng         = 32'hd9b3_6e41;
        test_name   = "reset";
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i].word = mem_pkg::INIT_WORD;
        end
        repeat (5) @(posedge wb_clk_i);
        arst_n_i <= 1'b1;

        // First read waits out the whole fill before it is served
        test_name = "init_fill";
        for (int i = 0; i < MEM_WORDS; i++) begin
            read_word(32'(i * mem_pkg::SEL_W));
        end
        idle_bus(1);

        test_name = "latency";
        write_lanes(32'h0000_0040, 32'h1234_5678, 4'hf);
        read_word(32'h0000_0040);
        idle_bus(1);

        test_name = "byte_lanes";
        lanes[0] = 4'h1;
        lanes[1] = 4'h6;
        lanes[2] = 4'h8;
        lanes[3] = 4'ha;
        for (int i = 0; i < 4; i++) begin
            rng = lcg_next(rng);
            write_lanes(32'h0000_0014, rng, lanes[i]);
            read_word(32'h0000_0014);
        end
        idle_bus(1);

        // Word 2 aliases the first bad address and must stay untouched
        test_name = "out_of_range";
        write_lanes(32'(MEM_WORDS * mem_pkg::SEL_W + 8), 32'hdead_beef, 4'hf);
        read_word(32'hffff_fffc);
        read_word(32'h0000_0008);
        idle_bus(1);

        test_name = "random";
        for (int n = 0; n < N_RANDOM; n++) begin
            rng = lcg_next(rng);
            adr = 32'((int'(rng[23:16]) % MEM_WORDS) * mem_pkg::SEL_W);
            we  = rng[30];
            sel = rng[11:8];
            rng = lcg_next(rng);
            if (we) begin
                write_lanes(adr, rng, sel);
            end else begin
                read_word(adr);
            end
        end
        idle_bus(2);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+sim
design/mem_pkg.sv
design/init_counter.sv
design/sram_bank.sv
design/mem_fsm.sv
design/wb_mem_top.sv
sim/tb_wb_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_wb_mem -f sim.f -o tb_wb_mem_sim

sim_out=$(./obj_dir/tb_wb_mem_sim 2>&1) || true
echo "$sim_out"

if grep -q "all tests passed" <<< "$sim_out"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
